// File: source/tsn_params.svh
`ifndef TSN_PARAMS_SVH
`define TSN_PARAMS_SVH

// port count and GMII byte width
`define NUM_PORTS       4
`define GMII_DW         8

// statistics counters, wrap at full scale
`define CNT_W           16

// system clocks per MDC half period
`define MDC_DIV         4

// external PHY
`define PHY_ADDR        5'd1
`define PHY_RST_CYCLES  16

// one clause-22 write frame
`define SMI_FRAME_BITS  64

`endif

// File: source/tsn_pkg.sv
package tsn_pkg;

    // SMI master
    typedef enum logic {
        SMI_IDLE  = 1'b0,
        SMI_SHIFT = 1'b1
    } smi_state_t;

    // power-on sequencer
    typedef enum logic [1:0] {
        INIT_PHY_RST = 2'd0,
        INIT_WRITE   = 2'd1,
        INIT_WAIT    = 2'd2,
        INIT_DONE    = 2'd3
    } init_state_t;

    // host read counter select
    typedef enum logic {
        CNT_INPKT   = 1'b0,
        CNT_DISCARD = 1'b1
    } cnt_sel_t;

endpackage

// File: source/smi_cmd_if.sv
`timescale 1ns/1ps

interface smi_cmd_if;
    logic        start;     // one-cycle request
    logic [4:0]  reg_addr;  // PHY register number
    logic [15:0] wr_data;
    logic        busy;      // frame in progress

    modport seq (
        output start, reg_addr, wr_data,
        input  busy
    );

    modport mst (
        input  start, reg_addr, wr_data,
        output busy
    );
endinterface

// File: source/smi_master.sv
`timescale 1ns/1ps
`include "tsn_params.svh"

module smi_master import tsn_pkg::*; (
    input  logic   FPGA_SYS_CLK,   // 125 MHz
    input  logic   FPGA_SYS_RST_N,
    smi_cmd_if.mst cmd,
    output logic   o_mdc,
    output logic   o_mdio,
    output logic   o_mdio_oe
);

localparam int DIV_W = $clog2(`MDC_DIV);
localparam int BIT_W = $clog2(`SMI_FRAME_BITS);

smi_state_t                 state;
logic [DIV_W-1:0]           div_cnt;
logic [BIT_W-1:0]           bit_cnt;
logic [`SMI_FRAME_BITS-1:0] shift_reg;
logic [`SMI_FRAME_BITS-1:0] frame;
logic                       div_wrap;
logic                       mdc_fall;

// preamble, start, write op, phy addr, reg addr, turnaround, data
assign frame = {32'hffff_ffff, 2'b01, 2'b01, `PHY_ADDR, cmd.reg_addr, 2'b10, cmd.wr_data};

assign div_wrap  = (div_cnt == DIV_W'(`MDC_DIV - 1));
assign mdc_fall  = div_wrap & o_mdc;   // mdc about to go low
assign o_mdio_oe = (state == SMI_SHIFT);
assign cmd.busy  = (state == SMI_SHIFT);
assign o_mdio    = o_mdio_oe ? shift_reg[`SMI_FRAME_BITS-1] : 1'b1;  // msb first

always_ff @(posedge FPGA_SYS_CLK) begin
    if (!FPGA_SYS_RST_N) begin
        state   <= SMI_IDLE;
        div_cnt <= '0;
        bit_cnt <= '0;
        o_mdc   <= 1'b0;
    end else begin
        case (state)
            SMI_IDLE: begin
                if (cmd.start) begin
                    state   <= SMI_SHIFT;
                    div_cnt <= '0;
                    bit_cnt <= '0;
                    o_mdc   <= 1'b0;
                end
            end
            SMI_SHIFT: begin
                div_cnt <= div_wrap ? '0 : div_cnt + 1'b1;
                if (div_wrap) begin
                    o_mdc <= ~o_mdc;
                end
                if (mdc_fall) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == BIT_W'(`SMI_FRAME_BITS - 1)) begin
                        state <= SMI_IDLE;   // last mdc period done
                    end
                end
            end
            default: state <= SMI_IDLE;
        endcase
    end
end

// frame shifter, advances on falling mdc
always_ff @(posedge FPGA_SYS_CLK) begin
    if (state == SMI_IDLE && cmd.start) begin
        shift_reg <= frame;
    end else if (state == SMI_SHIFT && mdc_fall) begin
        shift_reg <= {shift_reg[`SMI_FRAME_BITS-2:0], 1'b1};
    end
end

endmodule

// File: source/phy_init_seq.sv
`timescale 1ns/1ps
`include "tsn_params.svh"

module phy_init_seq import tsn_pkg::*; (
    input  logic   FPGA_SYS_CLK,   // 125 MHz
    input  logic   FPGA_SYS_RST_N,
    smi_cmd_if.seq cmd,
    output logic   o_phy_rst_n,
    output logic   o_init_done
);

localparam int RST_W = $clog2(`PHY_RST_CYCLES);

init_state_t      state;
logic [RST_W-1:0] rst_cnt;
logic [1:0]       wr_idx;      // write table entry

// fixed phy write table
always_comb begin
    case (wr_idx)
        2'd0: begin
            cmd.reg_addr = 5'd0;     // bmcr, autoneg on, 1000 full
            cmd.wr_data  = 16'h1140;
        end
        2'd1: begin
            cmd.reg_addr = 5'd4;     // advertise 10/100
            cmd.wr_data  = 16'h01e1;
        end
        default: begin
            cmd.reg_addr = 5'd9;     // advertise 1000
            cmd.wr_data  = 16'h0300;
        end
    endcase
end

assign cmd.start   = (state == INIT_WRITE);
assign o_init_done = (state == INIT_DONE);

always_ff @(posedge FPGA_SYS_CLK) begin
    if (!FPGA_SYS_RST_N) begin
        state       <= INIT_PHY_RST;
        rst_cnt     <= '0;
        wr_idx      <= 2'd0;
        o_phy_rst_n <= 1'b0;
    end else begin
        case (state)
            INIT_PHY_RST: begin
                rst_cnt <= rst_cnt + 1'b1;
                if (rst_cnt == RST_W'(`PHY_RST_CYCLES - 1)) begin
                    o_phy_rst_n <= 1'b1;  // release phy
                    state       <= INIT_WRITE;
                end
            end
            INIT_WRITE: state <= INIT_WAIT;  // master latches the command here
            INIT_WAIT: begin
                if (!cmd.busy) begin
                    if (wr_idx == 2'd2) begin
                        state <= INIT_DONE;
                    end else begin
                        wr_idx <= wr_idx + 1'b1;
                        state  <= INIT_WRITE;
                    end
                end
            end
            default: state <= INIT_DONE;  // done is terminal
        endcase
    end
end

endmodule

// File: source/gmii_port_path.sv
`timescale 1ns/1ps
`include "tsn_params.svh"

module gmii_port_path (
    input  logic               FPGA_SYS_CLK,   // 125 MHz
    input  logic               FPGA_SYS_RST_N,
    input  logic               i_rx_dv,
    input  logic [`GMII_DW-1:0] i_rxd,
    input  logic               i_rx_er,
    output logic               o_tx_en,
    output logic [`GMII_DW-1:0] o_txd,
    output logic               o_tx_er,
    output logic               o_inpkt_pulse,
    output logic               o_discard_pulse
);

logic               dv_d1;
logic               er_d1;
logic [`GMII_DW-1:0] rxd_d1;
logic               err_seen;  // er seen in current frame
logic               frame_end;

assign frame_end = dv_d1 & ~i_rx_dv;   // first idle cycle after a frame

always_ff @(posedge FPGA_SYS_CLK) begin
    if (!FPGA_SYS_RST_N) begin
        dv_d1           <= 1'b0;
        er_d1           <= 1'b0;
        o_tx_en         <= 1'b0;
        o_tx_er         <= 1'b0;
        err_seen        <= 1'b0;
        o_inpkt_pulse   <= 1'b0;
        o_discard_pulse <= 1'b0;
    end else begin
        dv_d1           <= i_rx_dv;
        er_d1           <= i_rx_er;
        o_tx_en         <= dv_d1;
        o_tx_er         <= er_d1;
        o_inpkt_pulse   <= frame_end;
        o_discard_pulse <= frame_end & err_seen;
        if (frame_end) begin
            err_seen <= 1'b0;
        end else if (i_rx_dv && i_rx_er) begin
            err_seen <= 1'b1;
        end
    end
end

// data stages
always_ff @(posedge FPGA_SYS_CLK) begin
    rxd_d1 <= i_rxd;
    o_txd  <= rxd_d1;
end

endmodule

// File: source/pkt_stats_regs.sv
`timescale 1ns/1ps
`include "tsn_params.svh"

module pkt_stats_regs import tsn_pkg::*; (
    input  logic                           FPGA_SYS_CLK,   // 125 MHz
    input  logic                           FPGA_SYS_RST_N,
    input  logic [`NUM_PORTS-1:0]          i_inpkt_pulse,
    input  logic [`NUM_PORTS-1:0]          i_discard_pulse,
    input  logic                           i_rd_req,
    input  logic [$clog2(`NUM_PORTS)-1:0]  i_rd_port,
    input  cnt_sel_t                       i_rd_sel,
    output logic                           o_rd_ack,
    output logic [`CNT_W-1:0]              o_rd_data
);

logic [`CNT_W-1:0] inpkt_cnt   [`NUM_PORTS];
logic [`CNT_W-1:0] discard_cnt [`NUM_PORTS];

always_ff @(posedge FPGA_SYS_CLK) begin
    if (!FPGA_SYS_RST_N) begin
        for (int p = 0; p < `NUM_PORTS; p++) begin
            inpkt_cnt[p]   <= '0;
            discard_cnt[p] <= '0;
        end
    end else begin
        for (int p = 0; p < `NUM_PORTS; p++) begin
            if (i_inpkt_pulse[p]) begin
                inpkt_cnt[p] <= inpkt_cnt[p] + 1'b1;   // wraps
            end
            if (i_discard_pulse[p]) begin
                discard_cnt[p] <= discard_cnt[p] + 1'b1;
            end
        end
    end
end

always_ff @(posedge FPGA_SYS_CLK) begin
    if (!FPGA_SYS_RST_N) begin
        o_rd_ack <= 1'b0;
    end else begin
        o_rd_ack <= i_rd_req;
    end
end

// snapshot at the request edge
always_ff @(posedge FPGA_SYS_CLK) begin
    if (i_rd_req) begin
        o_rd_data <= (i_rd_sel == CNT_DISCARD) ? discard_cnt[i_rd_port] : inpkt_cnt[i_rd_port];
    end
end

endmodule

// File: source/tsn_fpga_top.sv
`timescale 1ns/1ps
`include "tsn_params.svh"

module tsn_fpga_top import tsn_pkg::*; (
    input  logic                                FPGA_SYS_CLK,   // 125 MHz
    input  logic                                FPGA_SYS_RST_N,
    // external phy
    output logic                                o_phy_rst_n,
    output logic                                o_phy_mdc,
    output logic                                o_phy_mdio,
    output logic                                o_phy_mdio_oe,
    output logic                                o_init_done,
    // gmii
    input  logic [`NUM_PORTS-1:0]               i_gmii_rx_dv,
    input  logic [`NUM_PORTS-1:0]               i_gmii_rx_er,
    input  logic [`NUM_PORTS-1:0][`GMII_DW-1:0] i_gmii_rxd,
    output logic [`NUM_PORTS-1:0]               o_gmii_tx_en,
    output logic [`NUM_PORTS-1:0]               o_gmii_tx_er,
    output logic [`NUM_PORTS-1:0][`GMII_DW-1:0] o_gmii_txd,
    // host counter read
    input  logic                                i_rd_req,
    input  logic [$clog2(`NUM_PORTS)-1:0]       i_rd_port,
    input  cnt_sel_t                            i_rd_sel,
    output logic                                o_rd_ack,
    output logic [`CNT_W-1:0]                   o_rd_data
);

logic [`NUM_PORTS-1:0] w_inpkt_pulse;
logic [`NUM_PORTS-1:0] w_discard_pulse;

smi_cmd_if smi_cmd_i ();

phy_init_seq phy_init_seq_i (
    .FPGA_SYS_CLK   (FPGA_SYS_CLK),
    .FPGA_SYS_RST_N (FPGA_SYS_RST_N),
    .cmd            (smi_cmd_i.seq),
    .o_phy_rst_n    (o_phy_rst_n),
    .o_init_done    (o_init_done)
);

smi_master smi_master_i (
    .FPGA_SYS_CLK   (FPGA_SYS_CLK),
    .FPGA_SYS_RST_N (FPGA_SYS_RST_N),
    .cmd            (smi_cmd_i.mst),
    .o_mdc          (o_phy_mdc),
    .o_mdio         (o_phy_mdio),
    .o_mdio_oe      (o_phy_mdio_oe)
);

genvar gi;
generate
    for (gi = 0; gi < `NUM_PORTS; gi++) begin : g_port
        gmii_port_path gmii_port_path_i (
            .FPGA_SYS_CLK    (FPGA_SYS_CLK),
            .FPGA_SYS_RST_N  (FPGA_SYS_RST_N),
            .i_rx_dv         (i_gmii_rx_dv[gi]),
            .i_rxd           (i_gmii_rxd[gi]),
            .i_rx_er         (i_gmii_rx_er[gi]),
            .o_tx_en         (o_gmii_tx_en[gi]),
            .o_txd           (o_gmii_txd[gi]),
            .o_tx_er         (o_gmii_tx_er[gi]),
            .o_inpkt_pulse   (w_inpkt_pulse[gi]),
            .o_discard_pulse (w_discard_pulse[gi])
        );
    end
endgenerate

pkt_stats_regs pkt_stats_regs_i (
    .FPGA_SYS_CLK    (FPGA_SYS_CLK),
    .FPGA_SYS_RST_N  (FPGA_SYS_RST_N),
    .i_inpkt_pulse   (w_inpkt_pulse),
    .i_discard_pulse (w_discard_pulse),
    .i_rd_req        (i_rd_req),
    .i_rd_port       (i_rd_port),
    .i_rd_sel        (i_rd_sel),
    .o_rd_ack        (o_rd_ack),
    .o_rd_data       (o_rd_data)
);

endmodule

// File: bench/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 5
) (
    output logic o_clk,
    output logic o_rst_n
);

initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
end

initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    #2 o_rst_n = 1'b1;   // released with the stimulus skew
end

endmodule

// File: bench/tsn_fpga_sva.sv
`timescale 1ns/1ps
`include "tsn_params.svh"

module tsn_fpga_sva (
    input logic                  FPGA_SYS_CLK,
    input logic                  FPGA_SYS_RST_N,
    input logic                  o_phy_rst_n,
    input logic                  o_phy_mdio_oe,
    input logic                  o_init_done,
    input logic                  i_rd_req,
    input logic                  o_rd_ack,
    input logic [`NUM_PORTS-1:0] i_gmii_rx_dv,
    input logic [`NUM_PORTS-1:0] o_gmii_tx_en
);

// mdio is only driven once the phy is out of reset
a_mdio_oe_phy_up: assert property (@(posedge FPGA_SYS_CLK) disable iff (!FPGA_SYS_RST_N)
    o_phy_mdio_oe |-> o_phy_rst_n)
    else $error("mdio driven while the phy is held in reset");

a_ack_follows_req: assert property (@(posedge FPGA_SYS_CLK) disable iff (!FPGA_SYS_RST_N)
    o_rd_ack |-> $past(i_rd_req))
    else $error("read acknowledge without a request in the previous cycle");

a_init_done_sticky: assert property (@(posedge FPGA_SYS_CLK) disable iff (!FPGA_SYS_RST_N)
    o_init_done |=> o_init_done)
    else $error("init done fell after it was raised");

a_tx_en_delay: assert property (@(posedge FPGA_SYS_CLK) disable iff (!FPGA_SYS_RST_N)
    o_gmii_tx_en == $past(i_gmii_rx_dv, 2))
    else $error("gmii tx_en is not rx_dv delayed by two clocks");

endmodule

bind tsn_fpga_top tsn_fpga_sva tsn_fpga_sva_i (
    .FPGA_SYS_CLK   (FPGA_SYS_CLK),
    .FPGA_SYS_RST_N (FPGA_SYS_RST_N),
    .o_phy_rst_n    (o_phy_rst_n),
    .o_phy_mdio_oe  (o_phy_mdio_oe),
    .o_init_done    (o_init_done),
    .i_rd_req       (i_rd_req),
    .o_rd_ack       (o_rd_ack),
    .i_gmii_rx_dv   (i_gmii_rx_dv),
    .o_gmii_tx_en   (o_gmii_tx_en)
);

// File: bench/tb_tsn_fpga_top.sv
`timescale 1ns/1ps
`include "tsn_params.svh"

module tb_tsn_fpga_top import tsn_pkg::*; ();

localparam int NP = `NUM_PORTS;
localparam int DW = `GMII_DW;
localparam int PW = $clog2(`NUM_PORTS);
localparam int TIMEOUT_CYCLES = 6000;  // init ~1600, two traffic passes ~900, reads, margin

logic                   FPGA_SYS_CLK;
logic                   FPGA_SYS_RST_N;
logic                   phy_rst_n, phy_mdc, phy_mdio, phy_mdio_oe, init_done;
logic [NP-1:0]          rx_dv, rx_er, tx_en, tx_er;
logic [NP-1:0][DW-1:0]  rxd, txd;
logic                   rd_req, rd_ack;
logic [PW-1:0]          rd_port;
cnt_sel_t               rd_sel;
logic [`CNT_W-1:0]      rd_data;

integer                 seed;
int                     err_cnt;
int                     cycle_cnt;
bit                     sent_err [NP][$];     // per frame, any er byte
int                     mark [NP];            // frames sent before the second pass
logic [`CNT_W-1:0]      first_rd [NP][2];
logic [NP-1:0][DW+1:0]  hist1, hist2;         // {dv, er, rxd} one and two clocks back
logic                   req_prev;

clk_gen #(.PERIOD_NS(20), .RST_CYCLES(5)) clk_gen_i (
    .o_clk   (FPGA_SYS_CLK),
    .o_rst_n (FPGA_SYS_RST_N)
);

tsn_fpga_top tsn_fpga_top_i (
    .FPGA_SYS_CLK   (FPGA_SYS_CLK),
    .FPGA_SYS_RST_N (FPGA_SYS_RST_N),
    .o_phy_rst_n    (phy_rst_n),
    .o_phy_mdc      (phy_mdc),
    .o_phy_mdio     (phy_mdio),
    .o_phy_mdio_oe  (phy_mdio_oe),
    .o_init_done    (init_done),
    .i_gmii_rx_dv   (rx_dv),
    .i_gmii_rx_er   (rx_er),
    .i_gmii_rxd     (rxd),
    .o_gmii_tx_en   (tx_en),
    .o_gmii_tx_er   (tx_er),
    .o_gmii_txd     (txd),
    .i_rd_req       (rd_req),
    .i_rd_port      (rd_port),
    .i_rd_sel       (rd_sel),
    .o_rd_ack       (rd_ack),
    .o_rd_data      (rd_data)
);

// clause-22 write frame for one entry of the phy table
function automatic logic [`SMI_FRAME_BITS-1:0] smi_frame(input int idx);
    logic [4:0]  ra;
    logic [15:0] wd;
    case (idx)
        0: begin
            ra = 5'd0;
            wd = 16'h1140;
        end
        1: begin
            ra = 5'd4;
            wd = 16'h01e1;
        end
        default: begin
            ra = 5'd9;
            wd = 16'h0300;
        end
    endcase
    return {32'hffff_ffff, 2'b01, 2'b01, `PHY_ADDR, ra, 2'b10, wd};
endfunction

function automatic logic [`CNT_W-1:0] expected_count(input int p, input cnt_sel_t sel,
                                                     input int from);
    logic [`CNT_W-1:0] n;
    n = '0;
    for (int i = from; i < sent_err[p].size(); i++) begin
        if (sel == CNT_INPKT || sent_err[p][i]) n++;   // wraps like the hardware
    end
    return n;
endfunction

function automatic logic [DW+1:0] expected_tx(input int p);
    return hist2[p];   // tx is rx two clocks back
endfunction

task automatic report_error(input string msg);
    err_cnt++;
    $display("ERR %0t: %s", $time, msg);
    $display("*** FAILED ***");
    $fatal(1, "stopped at the first error");
endtask

task automatic check_reset_phase();
    int n;
    n = 0;
    wait (FPGA_SYS_RST_N);
    while (!phy_rst_n) begin
        @(posedge FPGA_SYS_CLK);
        @(negedge FPGA_SYS_CLK);
        n++;
        assert (!phy_mdio_oe && !phy_mdc && !init_done &&
                tx_en == '0 && tx_er == '0 && !rd_ack)
            else report_error("outputs not idle while the phy is in reset");
    end
    assert (n == `PHY_RST_CYCLES)
        else report_error($sformatf("phy reset released after %0d cycles, expected %0d",
                                    n, `PHY_RST_CYCLES));
endtask

// decode mdio on rising mdc, seen at the falling system clock
task automatic check_smi_frames();
    logic [`SMI_FRAME_BITS-1:0] got;
    logic                       mdc_prev;
    int                         nbits;
    int                         nframe;
    int                         n;
    got = '0;
    mdc_prev = 1'b0;
    nbits = 0;
    nframe = 0;
    while (nframe < 3) begin
        @(negedge FPGA_SYS_CLK);
        if (phy_mdio_oe) begin
            if (phy_mdc && !mdc_prev) begin
                got = {got[`SMI_FRAME_BITS-2:0], phy_mdio};
                nbits++;
            end
        end else if (nbits > 0) begin   // frame just ended
            assert (nbits == `SMI_FRAME_BITS)
                else report_error($sformatf("smi frame %0d had %0d bits", nframe, nbits));
            assert (got == smi_frame(nframe))
                else report_error($sformatf("smi frame %0d = %h, expected %h",
                                            nframe, got, smi_frame(nframe)));
            nframe++;
            nbits = 0;
        end
        mdc_prev = phy_mdc;
    end
    n = 0;
    while (!init_done && n < 4) begin
        @(negedge FPGA_SYS_CLK);
        n++;
    end
    assert (init_done) else report_error("init done not raised after the third write");
endtask

// random frames on all ports, one process keeps the random sequence fixed
task automatic run_traffic(input int n_frames);
    int bytes_left  [NP];
    int gap_left    [NP];
    int frames_left [NP];
    int err_at      [NP];
    int idx         [NP];
    bit active;
    for (int p = 0; p < NP; p++) begin
        bytes_left[p]  = 0;
        gap_left[p]    = 2;
        frames_left[p] = n_frames;
        err_at[p]      = -1;
        idx[p]         = 0;
    end
    active = 1'b1;
    while (active) begin
        @(posedge FPGA_SYS_CLK);
        #2;
        active = 1'b0;
        for (int p = 0; p < NP; p++) begin
            if (bytes_left[p] == 0 && gap_left[p] == 0 && frames_left[p] > 0) begin
                bytes_left[p] = 4 + int'($unsigned($random(seed)) % 17);
                if (($random(seed) & 3) == 0) begin
                    err_at[p] = int'($unsigned($random(seed)) % bytes_left[p]);
                end else begin
                    err_at[p] = -1;
                end
                sent_err[p].push_back(err_at[p] >= 0);
                idx[p] = 0;
                frames_left[p]--;
            end
            rxd[p] = DW'($random(seed));   // idle bytes are forwarded too
            if (bytes_left[p] > 0) begin
                rx_dv[p] = 1'b1;
                rx_er[p] = (idx[p] == err_at[p]);
                idx[p]++;
                bytes_left[p]--;
                if (bytes_left[p] == 0) gap_left[p] = 2 + int'($unsigned($random(seed)) % 4);
            end else begin
                rx_dv[p] = 1'b0;
                rx_er[p] = 1'b0;
                if (gap_left[p] > 0) gap_left[p]--;
            end
            if (bytes_left[p] > 0 || gap_left[p] > 0 || frames_left[p] > 0) active = 1'b1;
        end
    end
endtask

task automatic read_counter(input int p, input cnt_sel_t sel, output logic [`CNT_W-1:0] val);
    @(posedge FPGA_SYS_CLK);
    #2;
    rd_req  = 1'b1;
    rd_port = PW'(p);
    rd_sel  = sel;
    @(posedge FPGA_SYS_CLK);
    #2;
    rd_req = 1'b0;
    @(negedge FPGA_SYS_CLK);
    assert (rd_ack) else report_error("no read acknowledge in the cycle after the request");
    val = rd_data;
endtask

task automatic check_counters(input bit second_pass);
    logic [`CNT_W-1:0] got;
    logic [`CNT_W-1:0] exp;
    cnt_sel_t          sel;
    for (int p = 0; p < NP; p++) begin
        for (int s = 0; s < 2; s++) begin
            sel = cnt_sel_t'(s);
            read_counter(p, sel, got);
            if (second_pass) begin
                exp = first_rd[p][s] + expected_count(p, sel, mark[p]);
            end else begin
                exp = expected_count(p, sel, 0);
            end
            assert (got == exp)
                else report_error($sformatf("port %0d %s count %0d, expected %0d",
                                            p, sel.name(), got, exp));
            first_rd[p][s] = exp;
        end
    end
endtask

// per-cycle compare of forwarding and read timing
always @(negedge FPGA_SYS_CLK) begin
    if (FPGA_SYS_RST_N) begin
        for (int p = 0; p < NP; p++) begin
            assert ({tx_en[p], tx_er[p], txd[p]} == expected_tx(p))
                else report_error($sformatf("port %0d tx {en,er,d} = %h, expected %h",
                                            p, {tx_en[p], tx_er[p], txd[p]}, expected_tx(p)));
        end
        assert (rd_ack == req_prev)
            else report_error($sformatf("o_rd_ack = %b, expected %b", rd_ack, req_prev));
    end
    hist2 = hist1;
    for (int p = 0; p < NP; p++) begin
        hist1[p] = {rx_dv[p], rx_er[p], rxd[p]};
    end
    req_prev = rd_req;
end

always @(posedge FPGA_SYS_CLK) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $fatal(1, "timeout");
    end
end

initial begin
    seed      = 32'hbbc5_8c9e;
    err_cnt   = 0;
    cycle_cnt = 0;
    req_prev  = 1'b0;
    rx_dv     = '0;
    rx_er     = '0;
    rxd       = '0;
    rd_req    = 1'b0;
    rd_port   = '0;
    rd_sel    = CNT_INPKT;
    check_reset_phase();
    fork
        check_smi_frames();
        run_traffic(40);
    join
    repeat (4) @(posedge FPGA_SYS_CLK);   // let the last event pulses land
    check_counters(1'b0);
    for (int p = 0; p < NP; p++) begin
        mark[p] = sent_err[p].size();
    end
    run_traffic(10);
    repeat (4) @(posedge FPGA_SYS_CLK);
    check_counters(1'b1);
    if (err_cnt == 0) begin
        $display("*** PASSED ***");
        $finish;
    end else begin
        $display("*** FAILED ***");
        $fatal(1, "errors were found");
    end
end

endmodule

// File: compile.f
+incdir+source
source/tsn_pkg.sv
source/smi_cmd_if.sv
source/smi_master.sv
source/phy_init_seq.sv
source/gmii_port_path.sv
source/pkt_stats_regs.sv
source/tsn_fpga_top.sv
bench/clk_gen.sv
bench/tsn_fpga_sva.sv
bench/tb_tsn_fpga_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, exit status is the verdict

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        -f compile.f --top-module tb_tsn_fpga_top -o tb_tsn_fpga_top; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_tsn_fpga_top
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

echo "simulation finished"
exit 0
